//--- hw/bay_ctrl_pkg.sv
/*
 * Bay controller shared definitions
 * Register map addresses, LED modes and the scaled timing constants
 * used by the bay-management blocks
 */

`default_nettype none

package bay_ctrl_pkg;

	// ************************************************************************
	// Bay and bus geometry
	// ************************************************************************

	localparam int DRIVE_COUNT = 8;
	localparam int DATA_WIDTH  = 8;
	localparam int ADDR_WIDTH  = 8;

	// Identification constants
	localparam logic [DATA_WIDTH-1:0] DEVICE_ID    = 8'hB5;
	localparam logic [DATA_WIDTH-1:0] CPLD_VERSION = 8'h12;

	// All bays enabled and gated by presence
	localparam logic [DRIVE_COUNT-1:0] PWR_EN_DEFAULT = '1;

	// ************************************************************************
	// Timing scaled for simulation
	// ************************************************************************

	localparam int DEBOUNCE_CYCLES  = 16;
	localparam int TICK_CYCLES      = 8;
	// Half periods in ticks
	localparam int FAST_HALF_TICKS  = 2;
	localparam int SLOW_HALF_TICKS  = 8;
	localparam int HEART_HALF_TICKS = 32;

	// Register map
	typedef enum logic [ADDR_WIDTH-1:0] {
		ADDR_ID       = 8'h00,
		ADDR_VERSION  = 8'h01,
		ADDR_PRESENT  = 8'h10,
		ADDR_PWR_EN   = 8'h20,
		ADDR_PWR_OK   = 8'h30,
		ADDR_AMBER_LO = 8'h40,
		ADDR_AMBER_HI = 8'h41,
		ADDR_BLUE_LO  = 8'h50,
		ADDR_BLUE_HI  = 8'h51,
		ADDR_ALERT    = 8'h90
	} reg_addr_e;

	// Per-LED mode with four drives per register byte
	typedef enum logic [1:0] {
		LED_OFF  = 2'd0,
		LED_ON   = 2'd1,
		LED_SLOW = 2'd2,
		LED_FAST = 2'd3
	} led_mode_e;

endpackage

`default_nettype wire

//--- hw/presence_filter.sv
/*
 * Drive presence filter
 * Two-flop synchronizer per bay and a debounce counter that accepts
 * a new level only after it has held for DEBOUNCE_CYCLES
 */

`timescale 1ns/1ps
`default_nettype none

module presence_filter
	import bay_ctrl_pkg::*;
(
	input  wire                    SYSCLK,
	input  wire                    RESET_N,
	input  wire  [DRIVE_COUNT-1:0] present_raw,
	output logic [DRIVE_COUNT-1:0] drive_present
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES);

	logic [DRIVE_COUNT-1:0] sync_meta;
	logic [DRIVE_COUNT-1:0] sync_q;
	logic [CNT_W-1:0]       stable_cnt [DRIVE_COUNT];

	// Bring the raw bay pins into the SYSCLK domain
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			sync_meta <= '0;
			sync_q    <= '0;
		end
		else
		begin
			sync_meta <= present_raw;
			sync_q    <= sync_meta;
		end
	end

	// Count cycles where the synced level disagrees with the accepted one
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			drive_present <= '0;
			for (int n = 0; n < DRIVE_COUNT; n++)
				stable_cnt[n] <= '0;
		end
		else
		begin
			for (int n = 0; n < DRIVE_COUNT; n++)
			begin
				if (sync_q[n] == drive_present[n])
					stable_cnt[n] <= '0;
				else if (stable_cnt[n] == CNT_W'(DEBOUNCE_CYCLES - 1))
				begin
					drive_present[n] <= sync_q[n];
					stable_cnt[n]    <= '0;
				end
				else
					stable_cnt[n] <= stable_cnt[n] + 1'b1;
			end
		end
	end

	// New level must have been on the synced bit for the whole window
	for (genvar n = 0; n < DRIVE_COUNT; n++)
	begin : g_chk
		a_settled: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
			$changed(drive_present[n]) |->
				($past(sync_q[n]) == drive_present[n]) &&
				($past(sync_q[n], DEBOUNCE_CYCLES) == drive_present[n]))
			else $error("presence bit %0d accepted before it settled", n);
	end

endmodule

`default_nettype wire

//--- hw/blink_timebase.sv
/*
 * Blink timebase
 * One free-running tick shared by the fast and slow LED blink
 * phases and the heartbeat output
 */

`timescale 1ns/1ps
`default_nettype none

module blink_timebase
	import bay_ctrl_pkg::*;
(
	input  wire  SYSCLK,
	input  wire  RESET_N,
	output logic slow_phase,
	output logic fast_phase,
	output logic heart
);

	localparam int DIV_W     = $clog2(TICK_CYCLES);
	localparam int HALF_W    = $clog2(HEART_HALF_TICKS);
	localparam int FAST_IDX  = 0;
	localparam int SLOW_IDX  = 1;
	localparam int HEART_IDX = 2;
	localparam int NUM_PHASE = 3;

	// Heartbeat is the longest half period and sets HALF_W
	localparam int HALF_TICKS [NUM_PHASE] = '{FAST_HALF_TICKS, SLOW_HALF_TICKS,
		HEART_HALF_TICKS};

	logic [DIV_W-1:0]     div_cnt;
	logic                 tick;
	logic [HALF_W-1:0]    half_cnt [NUM_PHASE];
	logic [NUM_PHASE-1:0] phase_q;

	// ************************************************************************
	// Tick divider
	// ************************************************************************

	assign tick = (div_cnt == DIV_W'(TICK_CYCLES - 1));

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ************************************************************************
	// Phase toggles on the shared tick
	// ************************************************************************

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			phase_q <= '0;
			for (int i = 0; i < NUM_PHASE; i++)
				half_cnt[i] <= '0;
		end
		else if (tick)
		begin
			for (int i = 0; i < NUM_PHASE; i++)
			begin
				if (half_cnt[i] == HALF_W'(HALF_TICKS[i] - 1))
				begin
					half_cnt[i] <= '0;
					phase_q[i]  <= ~phase_q[i];
				end
				else
					half_cnt[i] <= half_cnt[i] + 1'b1;
			end
		end
	end

	assign fast_phase = phase_q[FAST_IDX];
	assign slow_phase = phase_q[SLOW_IDX];
	assign heart      = phase_q[HEART_IDX];

	a_phase_on_tick: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		$changed(phase_q) |-> $past(tick))
		else $error("blink phase moved outside a tick");

endmodule

`default_nettype wire

//--- hw/bay_reg_file.sv
/*
 * Bay register file
 * Strobed register bus decode, power-enable and LED mode registers,
 * read mux for status and constants, presence-gated power outputs
 */

`timescale 1ns/1ps
`default_nettype none

module bay_reg_file
	import bay_ctrl_pkg::*;
(
	input  wire                         SYSCLK,
	input  wire                         RESET_N,
	input  wire  [ADDR_WIDTH-1:0]       reg_addr,
	input  wire  [DATA_WIDTH-1:0]       reg_wdata,
	input  wire                         wr_strobe,
	input  wire                         rd_strobe,
	output logic [DATA_WIDTH-1:0]       reg_rdata,
	input  wire  [DRIVE_COUNT-1:0]      drive_present,
	input  wire  [DRIVE_COUNT-1:0]      pwr_ok,
	input  wire                         alert_l,
	output led_mode_e [DRIVE_COUNT-1:0] amber_mode,
	output led_mode_e [DRIVE_COUNT-1:0] blue_mode,
	output logic [DRIVE_COUNT-1:0]      pwr_en_l,
	output logic [DRIVE_COUNT-1:0]      pcie_clk_oe_l
);

	localparam int MODE_W = $bits(led_mode_e);
	localparam int LED_W  = MODE_W * DRIVE_COUNT;

	reg_addr_e              addr;
	logic [DRIVE_COUNT-1:0] pwr_en_q;
	logic [LED_W-1:0]       amber_q;
	logic [LED_W-1:0]       blue_q;
	logic [DATA_WIDTH-1:0]  rd_mux;
	logic [DRIVE_COUNT-1:0] power_on;

	assign addr = reg_addr_e'(reg_addr);

	// ************************************************************************
	// Writable registers
	// ************************************************************************

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_en_q <= PWR_EN_DEFAULT;
			amber_q  <= '0;
			blue_q   <= '0;
		end
		else if (wr_strobe)
		begin
			// Read-only and unmapped addresses fall through
			case (addr)
				ADDR_PWR_EN:   pwr_en_q <= reg_wdata;
				ADDR_AMBER_LO: amber_q[DATA_WIDTH-1:0] <= reg_wdata;
				ADDR_AMBER_HI: amber_q[LED_W-1:DATA_WIDTH] <= reg_wdata;
				ADDR_BLUE_LO:  blue_q[DATA_WIDTH-1:0] <= reg_wdata;
				ADDR_BLUE_HI:  blue_q[LED_W-1:DATA_WIDTH] <= reg_wdata;
				default:       ;
			endcase
		end
	end

	// Unpack register bits into per-drive modes
	for (genvar n = 0; n < DRIVE_COUNT; n++)
	begin : g_mode
		assign amber_mode[n] = led_mode_e'(amber_q[MODE_W*n +: MODE_W]);
		assign blue_mode[n]  = led_mode_e'(blue_q[MODE_W*n +: MODE_W]);
	end

	// ************************************************************************
	// Read path
	// ************************************************************************

	always_comb
	begin
		case (addr)
			ADDR_ID:       rd_mux = DEVICE_ID;
			ADDR_VERSION:  rd_mux = CPLD_VERSION;
			ADDR_PRESENT:  rd_mux = drive_present;
			ADDR_PWR_EN:   rd_mux = pwr_en_q;
			ADDR_PWR_OK:   rd_mux = pwr_ok;
			ADDR_AMBER_LO: rd_mux = amber_q[DATA_WIDTH-1:0];
			ADDR_AMBER_HI: rd_mux = amber_q[LED_W-1:DATA_WIDTH];
			ADDR_BLUE_LO:  rd_mux = blue_q[DATA_WIDTH-1:0];
			ADDR_BLUE_HI:  rd_mux = blue_q[LED_W-1:DATA_WIDTH];
			// Enclosure alert shows as active high
			ADDR_ALERT:    rd_mux = {{(DATA_WIDTH-1){1'b0}}, ~alert_l};
			default:       rd_mux = '0;
		endcase
	end

	// Read data holds until the next read strobe
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			reg_rdata <= '0;
		else if (rd_strobe)
			reg_rdata <= rd_mux;
	end

	// ************************************************************************
	// Active-low power and PCIe clock enables
	// ************************************************************************

	assign power_on = pwr_en_q & drive_present;

	// Separate flops for the two pin groups
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_en_l      <= '1;
			pcie_clk_oe_l <= '1;
		end
		else
		begin
			pwr_en_l      <= ~power_on;
			pcie_clk_oe_l <= ~power_on;
		end
	end

	a_one_strobe: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		!(wr_strobe && rd_strobe))
		else $error("write and read strobes high together");

	// Presence seen by the power flops one cycle earlier
	a_no_power_absent: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		~|(~pwr_en_l & ~$past(drive_present)))
		else $error("power enabled on an empty bay");

	a_clk_oe_match: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		pcie_clk_oe_l == pwr_en_l)
		else $error("PCIe clock enable differs from power enable");

endmodule

`default_nettype wire

//--- hw/bay_led_drive.sv
/*
 * Bay LED driver
 * Selects each amber and blue LED level from its mode and the
 * shared blink phases, then registers it to the pins
 */

`timescale 1ns/1ps
`default_nettype none

module bay_led_drive
	import bay_ctrl_pkg::*;
(
	input  wire                         SYSCLK,
	input  wire                         RESET_N,
	input  var led_mode_e [DRIVE_COUNT-1:0] amber_mode,
	input  var led_mode_e [DRIVE_COUNT-1:0] blue_mode,
	input  wire                         slow_phase,
	input  wire                         fast_phase,
	output logic [DRIVE_COUNT-1:0]      amber_led,
	output logic [DRIVE_COUNT-1:0]      blue_led
);

	// Level for one LED in the current cycle
	function automatic logic led_level(led_mode_e mode, logic slow, logic fast);
		case (mode)
			LED_ON:   led_level = 1'b1;
			LED_SLOW: led_level = slow;
			LED_FAST: led_level = fast;
			default:  led_level = 1'b0;
		endcase
	endfunction

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			amber_led <= '0;
			blue_led  <= '0;
		end
		else
		begin
			for (int n = 0; n < DRIVE_COUNT; n++)
			begin
				amber_led[n] <= led_level(amber_mode[n], slow_phase, fast_phase);
				blue_led[n]  <= led_level(blue_mode[n], slow_phase, fast_phase);
			end
		end
	end

	// Steady modes show up on the pin one cycle later
	property p_steady(led_mode_e mode, logic led);
		@(posedge SYSCLK) disable iff (!RESET_N)
		(mode == LED_ON || mode == LED_OFF) |=> (led == $past(mode == LED_ON));
	endproperty

	for (genvar n = 0; n < DRIVE_COUNT; n++)
	begin : g_chk
		a_amber_steady: assert property (p_steady(amber_mode[n], amber_led[n]))
			else $error("amber LED %0d does not follow steady mode", n);
		a_blue_steady: assert property (p_steady(blue_mode[n], blue_led[n]))
			else $error("blue LED %0d does not follow steady mode", n);
	end

endmodule

`default_nettype wire

//--- hw/bay_ctrl_top.sv
/*
 * Bay controller top level
 * Connects presence filter, blink timebase, register file and LED driver
 */

`timescale 1ns/1ps
`default_nettype none

module bay_ctrl_top
	import bay_ctrl_pkg::*;
(
	input  wire                    SYSCLK,
	input  wire                    RESET_N,
	// Register bus
	input  wire  [ADDR_WIDTH-1:0]  reg_addr,
	input  wire  [DATA_WIDTH-1:0]  reg_wdata,
	input  wire                    wr_strobe,
	input  wire                    rd_strobe,
	output wire  [DATA_WIDTH-1:0]  reg_rdata,
	// Bay status inputs
	input  wire  [DRIVE_COUNT-1:0] present_raw,
	input  wire  [DRIVE_COUNT-1:0] pwr_ok,
	input  wire                    alert_l,
	// Bay control outputs
	output wire  [DRIVE_COUNT-1:0] pwr_en_l,
	output wire  [DRIVE_COUNT-1:0] pcie_clk_oe_l,
	output wire  [DRIVE_COUNT-1:0] amber_led,
	output wire  [DRIVE_COUNT-1:0] blue_led,
	output wire                    heart
);

	logic [DRIVE_COUNT-1:0]      drive_present;
	logic                        slow_phase;
	logic                        fast_phase;
	led_mode_e [DRIVE_COUNT-1:0] amber_mode;
	led_mode_e [DRIVE_COUNT-1:0] blue_mode;

	presence_filter u_presence (
		.SYSCLK        (SYSCLK),
		.RESET_N       (RESET_N),
		.present_raw   (present_raw),
		.drive_present (drive_present)
	);

	blink_timebase u_timebase (
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.slow_phase (slow_phase),
		.fast_phase (fast_phase),
		.heart      (heart)
	);

	bay_reg_file u_regs (
		.SYSCLK        (SYSCLK),
		.RESET_N       (RESET_N),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.wr_strobe     (wr_strobe),
		.rd_strobe     (rd_strobe),
		.reg_rdata     (reg_rdata),
		.drive_present (drive_present),
		.pwr_ok        (pwr_ok),
		.alert_l       (alert_l),
		.amber_mode    (amber_mode),
		.blue_mode     (blue_mode),
		.pwr_en_l      (pwr_en_l),
		.pcie_clk_oe_l (pcie_clk_oe_l)
	);

	bay_led_drive u_leds (
		.SYSCLK     (SYSCLK),
		.RESET_N    (RESET_N),
		.amber_mode (amber_mode),
		.blue_mode  (blue_mode),
		.slow_phase (slow_phase),
		.fast_phase (fast_phase),
		.amber_led  (amber_led),
		.blue_led   (blue_led)
	);

endmodule

`default_nettype wire

//--- testbench/tb_bay_ctrl.sv
/*
 * Bay controller testbench
 * Drives the register bus and bay pins of bay_ctrl_top and checks
 * identification, presence, power gating, LED modes, status and heartbeat
 */

`timescale 1ns/1ps
`default_nettype none

module tb_bay_ctrl
	import bay_ctrl_pkg::*;
;

	logic                   SYSCLK;
	logic                   RESET_N;
	logic [ADDR_WIDTH-1:0]  reg_addr;
	logic [DATA_WIDTH-1:0]  reg_wdata;
	logic                   wr_strobe;
	logic                   rd_strobe;
	wire  [DATA_WIDTH-1:0]  reg_rdata;
	logic [DRIVE_COUNT-1:0] present_raw;
	logic [DRIVE_COUNT-1:0] pwr_ok;
	logic                   alert_l;
	wire  [DRIVE_COUNT-1:0] pwr_en_l;
	wire  [DRIVE_COUNT-1:0] pcie_clk_oe_l;
	wire  [DRIVE_COUNT-1:0] amber_led;
	wire  [DRIVE_COUNT-1:0] blue_led;
	wire                    heart;

	int errors = 0;
	int checks = 0;
	int tests_failed = 0;

	bay_ctrl_top dut (
		.SYSCLK        (SYSCLK),
		.RESET_N       (RESET_N),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.wr_strobe     (wr_strobe),
		.rd_strobe     (rd_strobe),
		.reg_rdata     (reg_rdata),
		.present_raw   (present_raw),
		.pwr_ok        (pwr_ok),
		.alert_l       (alert_l),
		.pwr_en_l      (pwr_en_l),
		.pcie_clk_oe_l (pcie_clk_oe_l),
		.amber_led     (amber_led),
		.blue_led      (blue_led),
		.heart         (heart)
	);

	// 8 ns clock
	initial SYSCLK = 1'b0;
	always #4 SYSCLK = ~SYSCLK;

	// ************************************************************************
	// Pin-level checks that run the whole time
	// ************************************************************************

	a_clk_oe_pins: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		pcie_clk_oe_l == pwr_en_l)
		else
		begin
			$display("PCIe clock enable pins differ from power enable pins at %0t", $time);
			errors++;
		end

	// Read data only moves after a read strobe
	a_rdata_hold: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		!rd_strobe |=> $stable(reg_rdata))
		else
		begin
			$display("read data changed without a read strobe at %0t", $time);
			errors++;
		end

	// ************************************************************************
	// Helpers
	// ************************************************************************

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			$display("error %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		errors++;
	endtask

	// Bus cycles start and end on a falling edge
	task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] data);
		reg_addr  = addr;
		reg_wdata = data;
		wr_strobe = 1'b1;
		@(negedge SYSCLK);
		wr_strobe = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr,
		output logic [DATA_WIDTH-1:0] data);
		reg_addr  = addr;
		rd_strobe = 1'b1;
		@(negedge SYSCLK);
		rd_strobe = 1'b0;
		data = reg_rdata;
	endtask

	task automatic wait_present(input logic [DRIVE_COUNT-1:0] exp);
		logic [DATA_WIDTH-1:0] data;
		int tries;
		tries = 0;
		data = ~exp;
		while (data != exp && tries < 60)
		begin
			read_reg(ADDR_PRESENT, data);
			tries++;
		end
		if (data != exp)
			report_timeout("the debounced presence bits");
	endtask

	task automatic wait_power(input string name, input logic [DRIVE_COUNT-1:0] exp);
		int cycles;
		cycles = 0;
		while (pwr_en_l != exp && cycles < 8)
		begin
			@(negedge SYSCLK);
			cycles++;
		end
		check_value(name, exp, pwr_en_l);
	endtask

	// Index selects amber LEDs by drive, then blue, then the heartbeat
	function automatic logic sample_signal(input int sel);
		if (sel < DRIVE_COUNT)
			return amber_led[sel];
		else if (sel < 2 * DRIVE_COUNT)
			return blue_led[sel - DRIVE_COUNT];
		else
			return heart;
	endfunction

	task automatic wait_toggle(input int sel, input int limit, output int gap,
		output bit seen);
		logic prev;
		prev = sample_signal(sel);
		gap  = 0;
		seen = 1'b0;
		while (!seen && gap < limit)
		begin
			@(negedge SYSCLK);
			gap++;
			if (sample_signal(sel) != prev)
				seen = 1'b1;
		end
	endtask

	// First toggle aligns and the next two are measured
	task automatic check_period(input int sel, input int expected, input string name);
		int gap;
		bit seen;
		wait_toggle(sel, 2 * expected + 16, gap, seen);
		if (!seen)
			report_timeout({name, " first toggle"});
		for (int k = 0; k < 2; k++)
		begin
			wait_toggle(sel, 2 * expected + 16, gap, seen);
			if (!seen)
				report_timeout({name, " next toggle"});
			else
				check_value(name, expected, gap);
		end
	endtask

	function automatic led_mode_e mode_of(input logic [DATA_WIDTH-1:0] lo,
		input logic [DATA_WIDTH-1:0] hi, input int n);
		logic [DATA_WIDTH-1:0] byte_v;
		byte_v = (n < 4) ? lo : hi;
		return led_mode_e'(byte_v[2 * (n % 4) +: 2]);
	endfunction

	task automatic finish_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("test %-16s ok", name);
		else
		begin
			$display("test %-16s failed with %0d errors", name, errors - errors_before);
			tests_failed++;
		end
	endtask

	// ************************************************************************
	// Stimulus
	// ************************************************************************

	initial
	begin
		logic [DATA_WIDTH-1:0]  data;
		logic [DRIVE_COUNT-1:0] pres;
		logic [DRIVE_COUNT-1:0] en;
		logic [DRIVE_COUNT-1:0] pwr_before;
		logic [DATA_WIDTH-1:0]  led_regs [4];
		logic [ADDR_WIDTH-1:0]  led_addrs [4];
		int flip_idx;
		int err0;

		RESET_N     = 1'b0;
		reg_addr    = '0;
		reg_wdata   = '0;
		wr_strobe   = 1'b0;
		rd_strobe   = 1'b0;
		present_raw = '0;
		pwr_ok      = '0;
		alert_l     = 1'b1;
		void'($urandom(32'h235c_461b));
		led_addrs = '{ADDR_AMBER_LO, ADDR_AMBER_HI, ADDR_BLUE_LO, ADDR_BLUE_HI};

		repeat (2) @(negedge SYSCLK);
		RESET_N = 1'b1;

		// Reset state and identification
		err0 = errors;
		check_value("reset pwr_en_l", {DRIVE_COUNT{1'b1}}, pwr_en_l);
		check_value("reset amber_led", '0, amber_led);
		check_value("reset blue_led", '0, blue_led);
		check_value("reset heart", 1'b0, heart);
		check_value("reset rdata", '0, reg_rdata);
		read_reg(ADDR_ID, data);
		check_value("id", DEVICE_ID, data);
		read_reg(ADDR_VERSION, data);
		check_value("version", CPLD_VERSION, data);
		read_reg(8'h77, data);
		check_value("unmapped read", '0, data);
		finish_test("identification", err0);

		// Presence and power gating
		err0 = errors;
		pres = $urandom;
		present_raw = pres;
		wait_present(pres);
		wait_power("default power", ~(pres & PWR_EN_DEFAULT));
		en = $urandom;
		write_reg(ADDR_PWR_EN, en);
		read_reg(ADDR_PWR_EN, data);
		check_value("pwr_en readback", en, data);
		wait_power("written power", ~(pres & en));
		finish_test("presence_power", err0);

		// Short pulse on one bay must not reach the accepted bits
		err0 = errors;
		pwr_before = pwr_en_l;
		flip_idx = $urandom_range(DRIVE_COUNT - 1, 0);
		present_raw[flip_idx] = ~present_raw[flip_idx];
		repeat (DEBOUNCE_CYCLES - 4)
		begin
			@(negedge SYSCLK);
			check_value("glitch pwr_en_l", pwr_before, pwr_en_l);
		end
		present_raw = pres;
		for (int k = DEBOUNCE_CYCLES - 4; k < 40; k++)
		begin
			read_reg(ADDR_PRESENT, data);
			check_value("glitch present", pres, data);
			check_value("glitch pwr_en_l", pwr_before, pwr_en_l);
		end
		finish_test("glitch_reject", err0);

		// LED modes with amber drives 0..3 fixed at ON, OFF, FAST, SLOW
		err0 = errors;
		for (int r = 0; r < 4; r++)
			led_regs[r] = $urandom;
		led_regs[0] = {LED_SLOW, LED_FAST, LED_OFF, LED_ON};
		for (int r = 0; r < 4; r++)
			write_reg(led_addrs[r], led_regs[r]);
		for (int r = 0; r < 4; r++)
		begin
			read_reg(led_addrs[r], data);
			check_value("led readback", led_regs[r], data);
		end
		repeat (80)
		begin
			@(negedge SYSCLK);
			for (int n = 0; n < DRIVE_COUNT; n++)
			begin
				if (mode_of(led_regs[0], led_regs[1], n) == LED_ON)
					check_value("amber steady on", 1'b1, amber_led[n]);
				if (mode_of(led_regs[0], led_regs[1], n) == LED_OFF)
					check_value("amber steady off", 1'b0, amber_led[n]);
				if (mode_of(led_regs[2], led_regs[3], n) == LED_ON)
					check_value("blue steady on", 1'b1, blue_led[n]);
				if (mode_of(led_regs[2], led_regs[3], n) == LED_OFF)
					check_value("blue steady off", 1'b0, blue_led[n]);
			end
		end
		check_period(2, FAST_HALF_TICKS * TICK_CYCLES, "fast blink period");
		check_period(3, SLOW_HALF_TICKS * TICK_CYCLES, "slow blink period");
		finish_test("led_modes", err0);

		// Status readback at both alert levels
		err0 = errors;
		for (int k = 0; k < 4; k++)
		begin
			pwr_ok  = $urandom;
			alert_l = k[0];
			@(negedge SYSCLK);
			read_reg(ADDR_PWR_OK, data);
			check_value("pwr_ok read", pwr_ok, data);
			read_reg(ADDR_ALERT, data);
			check_value("alert read", {7'd0, ~alert_l}, data);
			write_reg(ADDR_PWR_OK, $urandom);
			write_reg(ADDR_ALERT, $urandom);
			read_reg(ADDR_PWR_OK, data);
			check_value("pwr_ok after write", pwr_ok, data);
			read_reg(ADDR_ALERT, data);
			check_value("alert after write", {7'd0, ~alert_l}, data);
		end
		finish_test("status", err0);

		err0 = errors;
		check_period(2 * DRIVE_COUNT, HEART_HALF_TICKS * TICK_CYCLES, "heartbeat period");
		finish_test("heartbeat", err0);

		$display("tests 6, failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hw/bay_ctrl_pkg.sv
hw/presence_filter.sv
hw/blink_timebase.sv
hw/bay_reg_file.sv
hw/bay_led_drive.sv
hw/bay_ctrl_top.sv
testbench/tb_bay_ctrl.sv
